// ==== project.f ====
verilog/codecParamPkg.sv
verilog/codecModelPkg.sv
verilog/codecIfs.sv
verilog/seqDivider.sv
verilog/intervalUnit.sv
verilog/bitPacker.sv
verilog/encoderFsm.sv
verilog/arithEncoderTop.sv
verif/tbArithEncoder.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv --timescale 1ns/1ps \
    --top-module tbArithEncoder --Mdir obj_dir -o simv -f project.f

simOut=$(./obj_dir/simv)
echo "$simOut"

if echo "$simOut" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

// ==== verif/tbArithEncoder.sv ====
// testbench for the arithmetic encoder with message table, reference model and handshake driver
`timescale 1ns/1ps

module tbArithEncoder;

    localparam int msgCount = 7;
    localparam int maxSymbols = 40;
    localparam int timeoutCycles = msgCount * maxSymbols * 400;
    localparam logic [63:0] wholeRange = 64'(codecParamPkg::WHOLE);
    localparam logic [63:0] halfBound = 64'(codecParamPkg::HALF);
    localparam logic [63:0] quarterBound = 64'(codecParamPkg::QUARTER);
    localparam logic [63:0] threeQuarterBound = 64'(codecParamPkg::THREE_QUARTERS);

    logic clk = 1'b0;
    logic rstn;
    logic start;
    logic [codecModelPkg::SYMBOL_W-1:0] symbol;
    logic newSymbolProvided;
    logic readSuccess;
    logic idle;
    logic newSymbolRequested;
    logic resultReady;
    logic [2:0] validOutputBytes;
    logic [codecParamPkg::OUT_W-1:0] out;

    // one hex digit per symbol, EOF is appended
    string msgText [msgCount] = '{
        "",
        "3a",
        "0f52c",
        "b71e",
        "fedcba98fedcba98fedcba98fedcba98fedcba9",   // rare symbols, many words
        "f0e1d2c3b4a59687f0e1d2c3",
        "3a"
    };
    int readDelayBits [msgCount] = '{0, 0, 1, 0, 3, 2, 2};   // width of random read delay
    int symDelayBits [msgCount] = '{0, 0, 1, 2, 0, 3, 2};

    logic [31:0] lfsrState = 32'h84a5;
    logic [31:0] expWords [$];          // expected output words of one message
    int expLastBytes;
    logic [31:0] packWord;
    int packBits;
    int pendingBits;
    int errors = 0;
    int cycles = 0;

    arithEncoderTop i_dut (
        .clk, .rstn, .start, .symbol, .newSymbolProvided, .readSuccess,
        .idle, .newSymbolRequested, .resultReady, .validOutputBytes, .out
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) begin
            $display("timeout after %0d cycles, the encoder stopped responding", cycles);
            $display("errors: %0d", errors);
            $display("Some tests failed");
            $finish;
        end
    end

    // galois LFSR, one step per bit taken
    function automatic int randBits(input int n);
        int value;
        int k;
        value = 0;
        for (k = 0; k < n; k++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
            value = (value << 1) | int'(lfsrState[0]);
        end
        return value;
    endfunction

    function automatic logic [codecModelPkg::SYMBOL_W-1:0] symbolAt(input int m, input int i);
        string txt;
        logic [7:0] c;
        txt = msgText[m];
        if (i >= txt.len()) return codecModelPkg::EOF_SYMBOL;
        c = txt.getc(i);
        if (c <= 8'h39) return codecModelPkg::SYMBOL_W'(c - 8'h30);
        return codecModelPkg::SYMBOL_W'(c - 8'h57);   // lower case a to f
    endfunction

    function automatic void packBit(input logic v);
        packWord[packBits] = v;                        // lsb first
        packBits++;
        if (packBits == 32) begin
            expWords.push_back(packWord);
            packWord = '0;
            packBits = 0;
        end
    endfunction

    function automatic void emitBit(input logic v);
        int k;
        packBit(v);
        for (k = 0; k < pendingBits; k++) packBit(~v);
        pendingBits = 0;
    endfunction

    // expected words and last valid byte count of message m
    function automatic void buildExpected(input int m);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] w;
        logic [codecModelPkg::SYMBOL_W-1:0] s;
        logic scaling;
        int i;
        expWords.delete();
        packWord = '0;
        packBits = 0;
        pendingBits = 0;
        a = 64'd0;
        b = wholeRange;
        w = wholeRange;
        for (i = 0; i <= msgText[m].len(); i++) begin
            s = symbolAt(m, i);
            b = a + (w * 64'(codecModelPkg::CUM_FREQ[int'(s) + 1]))
                / 64'(codecModelPkg::TOTAL_FREQ);
            a = a + (w * 64'(codecModelPkg::CUM_FREQ[int'(s)])) / 64'(codecModelPkg::TOTAL_FREQ);
            scaling = 1'b1;
            while (scaling) begin
                if (b < halfBound) begin
                    emitBit(1'b0);
                    a = a << 1;
                    b = b << 1;
                end else if (a >= halfBound) begin
                    emitBit(1'b1);
                    a = (a - halfBound) << 1;
                    b = (b - halfBound) << 1;
                end else if (a > quarterBound && b < threeQuarterBound) begin
                    pendingBits++;                     // middle case
                    a = (a - quarterBound) << 1;
                    b = (b - quarterBound) << 1;
                end else begin
                    scaling = 1'b0;
                end
            end
            w = b - a;
        end
        pendingBits++;
        emitBit(a > quarterBound);
        if (packBits != 0) begin
            expWords.push_back(packWord);
            expLastBytes = (packBits + 7) / 8;
        end else begin
            expLastBytes = 4;
        end
    endfunction

    function automatic void checkWord(input int m, input int idx);
        int expBytes;
        if (idx >= expWords.size()) begin
            errors++;
            $display("FAIL %0t: msg %0d gave extra word %0d value %h", $time, m, idx, out);
            return;
        end
        expBytes = (idx == expWords.size() - 1) ? expLastBytes : 4;
        if (out !== expWords[idx]) begin
            errors++;
            $display("FAIL %0t: msg %0d word %0d out %h expected %h",
                     $time, m, idx, out, expWords[idx]);
        end
        if (int'(validOutputBytes) != expBytes) begin
            errors++;
            $display("FAIL %0t: msg %0d word %0d validOutputBytes %0d expected %0d",
                     $time, m, idx, validOutputBytes, expBytes);
        end
    endfunction

    // serves both four-phase handshakes until idle comes back
    task automatic runMessage(input int m);
        int symIdx;
        int wordIdx;
        int requests;
        int symPhase;
        int readPhase;
        int symWait;
        int readWait;
        logic finished;
        buildExpected(m);
        @(posedge clk);
        start <= 1'b1;
        symbol <= symbolAt(m, 0);
        @(posedge clk);
        start <= 1'b0;
        symIdx = 1;
        wordIdx = 0;
        requests = 0;
        symPhase = 0;
        readPhase = 0;
        symWait = 0;
        readWait = 0;
        finished = 1'b0;
        while (!finished) begin
            @(posedge clk);
            case (symPhase)
                0: if (newSymbolRequested) begin
                    requests++;
                    symWait = randBits(symDelayBits[m]);
                    symPhase = 1;
                end
                1: if (symWait > 0) symWait--;
                   else begin
                    symbol <= symbolAt(m, symIdx);
                    symIdx++;
                    newSymbolProvided <= 1'b1;
                    symPhase = 2;
                end
                2: if (!newSymbolRequested) begin
                    symWait = randBits(symDelayBits[m]);
                    symPhase = 3;
                end
                default: if (symWait > 0) symWait--;
                   else begin
                    newSymbolProvided <= 1'b0;
                    symPhase = 0;
                end
            endcase
            case (readPhase)
                0: if (resultReady) begin
                    checkWord(m, wordIdx);
                    wordIdx++;
                    readWait = randBits(readDelayBits[m]);
                    readPhase = 1;
                end
                1: if (readWait > 0) readWait--;
                   else begin
                    readSuccess <= 1'b1;
                    readPhase = 2;
                end
                2: if (!resultReady) begin
                    readWait = randBits(readDelayBits[m]);
                    readPhase = 3;
                end
                default: if (readWait > 0) readWait--;
                   else begin
                    readSuccess <= 1'b0;
                    readPhase = 0;
                end
            endcase
            finished = idle && symPhase == 0 && readPhase == 0;
        end
        if (wordIdx != expWords.size()) begin
            errors++;
            $display("FAIL %0t: msg %0d read %0d words expected %0d",
                     $time, m, wordIdx, expWords.size());
        end
        if (requests != msgText[m].len()) begin
            errors++;
            $display("FAIL %0t: msg %0d saw %0d symbol requests expected %0d",
                     $time, m, requests, msgText[m].len());
        end
    endtask

    initial begin
        int m;
        rstn = 1'b0;
        start = 1'b0;
        symbol = '0;
        newSymbolProvided = 1'b0;
        readSuccess = 1'b0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        if (idle !== 1'b1 || resultReady !== 1'b0 || newSymbolRequested !== 1'b0
            || out !== '0) begin
            errors++;
            $display("FAIL %0t: after reset idle %b resultReady %b newSymbolRequested %b out %h",
                     $time, idle, resultReady, newSymbolRequested, out);
        end
        for (m = 0; m < msgCount; m++) begin
            runMessage(m);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog/arithEncoderTop.sv ====
// arithmetic encoder top level with FSM, interval unit, divider and bit packer
`timescale 1ns/1ps

module arithEncoderTop (
    input  logic clk,
    input  logic rstn,
    input  logic start,
    input  logic [codecModelPkg::SYMBOL_W-1:0] symbol,
    input  logic newSymbolProvided,
    input  logic readSuccess,
    output logic idle,
    output logic newSymbolRequested,
    output logic resultReady,
    output logic [2:0] validOutputBytes,
    output logic [codecParamPkg::OUT_W-1:0] out
);

    codecParamPkg::intervalOp_e op;
    logic [codecModelPkg::SYMBOL_W-1:0] curSymbol;
    logic subStart;
    logic subDone;
    logic [codecParamPkg::PRECISION-1:0] low;
    logic [codecParamPkg::PRECISION-1:0] high;

    divIf divBus ();
    emitIf emitBus ();

    encoderFsm i_fsm (
        .clk, .rstn, .start, .symbol, .newSymbolProvided, .readSuccess,
        .idle, .newSymbolRequested, .resultReady,
        .op, .curSymbol, .subStart, .subDone, .low, .high,
        .emitPort(emitBus.master)
    );

    intervalUnit i_interval (
        .clk, .rstn, .op, .symbol(curSymbol), .subStart, .subDone,
        .low, .high, .div(divBus.master)
    );

    seqDivider i_divider (.clk, .rstn, .div(divBus.slave));

    bitPacker i_packer (.clk, .rstn, .emitPort(emitBus.slave), .out, .validOutputBytes);

endmodule

// ==== verilog/bitPacker.sv ====
// output word packing of emitted and pending bits, with valid byte count
`timescale 1ns/1ps

module bitPacker (
    input  logic clk,
    input  logic rstn,
    emitIf.slave emitPort,
    output logic [codecParamPkg::OUT_W-1:0] out,
    output logic [2:0] validOutputBytes
);

    logic [$clog2(codecParamPkg::OUT_W)-1:0] bitPos;
    logic [codecParamPkg::MAX_PENDING_W-1:0] pendCnt;
    logic pendValue;
    logic draining;
    logic full;
    logic isFinal;
    logic lastBit;

    assign lastBit = (bitPos == 5'(codecParamPkg::OUT_W - 1));
    assign emitPort.wordFull = full;
    // bytes touched by the final word, full words are always 4
    assign validOutputBytes = isFinal ? 3'((6'(bitPos) + 6'd7) >> 3) : 3'd4;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out <= '0;
            bitPos <= '0;
            pendCnt <= '0;
            draining <= 1'b0;
            full <= 1'b0;
            isFinal <= 1'b0;
        end else if (emitPort.wordRead) begin
            out <= '0;
            bitPos <= '0;
            full <= 1'b0;
            isFinal <= 1'b0;
        end else if (!full) begin
            if (emitPort.emit) begin
                out[bitPos] <= emitPort.bitValue;
                pendValue <= ~emitPort.bitValue;    // pending bits are the opposite
                draining <= (pendCnt != '0);
                bitPos <= bitPos + 1'b1;
                full <= lastBit;
            end else if (draining && pendCnt != '0) begin
                out[bitPos] <= pendValue;
                pendCnt <= pendCnt - 1'b1;
                draining <= (pendCnt != 7'd1);
                bitPos <= bitPos + 1'b1;
                full <= lastBit;
            end else if (emitPort.addPending) begin
                pendCnt <= pendCnt + 1'b1;
            end else if (emitPort.flush && bitPos != '0) begin
                full <= 1'b1;                       // nothing to hand out if empty
                isFinal <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/codecIfs.sv ====
// divider request interface and bit emit interface with their modports
`timescale 1ns/1ps

interface divIf;
    logic                              start;      // one-cycle pulse, divider idle
    logic [codecParamPkg::PROD_W-1:0]  dividend;
    logic [codecModelPkg::FREQ_W-1:0]  divisor;
    logic                              done;       // one-cycle pulse
    logic [codecParamPkg::PROD_W-1:0]  quotient;   // valid while done

    modport master (output start, dividend, divisor, input done, quotient);
    modport slave (input start, dividend, divisor, output done, quotient);
endinterface

interface emitIf;
    logic emit;         // write bitValue, then drain pending bits
    logic bitValue;
    logic addPending;   // one more middle-case bit
    logic flush;        // close the final, possibly partial word
    logic wordFull;     // level, word waits for the reader
    logic wordRead;     // pulse, reader took the word

    modport master (output emit, bitValue, addPending, flush, wordRead, input wordFull);
    modport slave (input emit, bitValue, addPending, flush, wordRead, output wordFull);
endinterface

// ==== verilog/codecModelPkg.sv ====
// static probability model: symbol count, EOF symbol and cumulative frequency table
package codecModelPkg;

    localparam int NUM_SYMBOLS = 17;
    localparam int SYMBOL_W = 5;
    localparam logic [SYMBOL_W-1:0] EOF_SYMBOL = 5'd16;

    localparam int FREQ_W = 13;
    localparam logic [FREQ_W-1:0] TOTAL_FREQ = 13'd4096;

    // symbol s owns [CUM_FREQ[s], CUM_FREQ[s+1])
    // low symbols get the largest shares, EOF gets 68 of 4096
    localparam logic [FREQ_W-1:0] CUM_FREQ [NUM_SYMBOLS+1] = '{
        0,    1024, 1664, 2176,
        2560, 2816, 3072, 3264,
        3424, 3552, 3664, 3760,
        3840, 3904, 3952, 3992,
        4028,
        4096
    };

endpackage

// ==== verilog/codecParamPkg.sv ====
// interval precision, datapath widths, interval constants and interval opcodes
package codecParamPkg;

    localparam int PRECISION = 20;

    // interval bounds in fixed point, WHOLE is 1.0
    localparam logic [PRECISION-1:0] WHOLE = PRECISION'(1 << (PRECISION - 1));
    localparam logic [PRECISION-1:0] HALF = PRECISION'(1 << (PRECISION - 2));
    localparam logic [PRECISION-1:0] QUARTER = PRECISION'(1 << (PRECISION - 3));
    localparam logic [PRECISION-1:0] THREE_QUARTERS = PRECISION'(3 << (PRECISION - 3));

    localparam int PROD_W = 38;         // product, dividend and quotient width
    localparam int OUT_W = 32;          // output word
    localparam int MAX_PENDING_W = 7;   // pending middle-case bit counter

    typedef enum logic [2:0] {
        OP_NONE,
        OP_LOAD,    // a = 0, b = w = WHOLE
        OP_LOW,     // expand lower half
        OP_HIGH,    // expand upper half
        OP_MID,     // expand middle half
        OP_WIDTH    // w = b - a
    } intervalOp_e;

endpackage

// ==== verilog/encoderFsm.sv ====
// encoder state machine for symbol intake, rescaling, flush and both handshakes
`timescale 1ns/1ps

module encoderFsm (
    input  logic clk,
    input  logic rstn,
    input  logic start,
    input  logic [codecModelPkg::SYMBOL_W-1:0] symbol,
    input  logic newSymbolProvided,
    input  logic readSuccess,
    output logic idle,
    output logic newSymbolRequested,
    output logic resultReady,
    output codecParamPkg::intervalOp_e op,
    output logic [codecModelPkg::SYMBOL_W-1:0] curSymbol,
    output logic subStart,
    input  logic subDone,
    input  logic [codecParamPkg::PRECISION-1:0] low,
    input  logic [codecParamPkg::PRECISION-1:0] high,
    emitIf.master emitPort
);

    typedef enum logic [3:0] {
        S_IDLE, S_SUB, S_RESCALE, S_FINISH, S_FLUSH_BIT, S_PENDING,
        S_FLUSH, S_FLUSHED, S_READ, S_READ_ACK, S_SYM_WAIT, S_SYM_ACK
    } state_e;

    state_e state;
    state_e retState;                                   // where a word read resumes
    logic [codecParamPkg::MAX_PENDING_W-1:0] pendCnt;   // tracks the packer's count
    logic flushing;

    assign idle = (state == S_IDLE);
    assign resultReady = (state == S_READ);
    assign newSymbolRequested = (state == S_SYM_WAIT);
    assign emitPort.wordRead = (state == S_READ) && readSuccess;

    always_comb begin
        op = codecParamPkg::OP_NONE;
        emitPort.emit = 1'b0;
        emitPort.bitValue = (low >= codecParamPkg::HALF);
        emitPort.addPending = 1'b0;
        emitPort.flush = 1'b0;
        unique case (state)
            S_IDLE: op = codecParamPkg::OP_LOAD;     // fresh interval for the next message
            S_RESCALE: begin
                if (high < codecParamPkg::HALF || low >= codecParamPkg::HALF) begin
                    emitPort.emit = 1'b1;
                    op = (high < codecParamPkg::HALF) ? codecParamPkg::OP_LOW
                                                      : codecParamPkg::OP_HIGH;
                end else if (low > codecParamPkg::QUARTER
                             && high < codecParamPkg::THREE_QUARTERS) begin
                    emitPort.addPending = 1'b1;
                    op = codecParamPkg::OP_MID;
                end else begin
                    op = codecParamPkg::OP_WIDTH;
                end
            end
            S_FINISH: emitPort.addPending = 1'b1;
            S_FLUSH_BIT: begin
                emitPort.emit = 1'b1;
                emitPort.bitValue = (low > codecParamPkg::QUARTER);
            end
            S_FLUSH: emitPort.flush = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_IDLE;
            retState <= S_IDLE;
            subStart <= 1'b0;
            pendCnt <= '0;
            flushing <= 1'b0;
        end else begin
            subStart <= 1'b0;
            unique case (state)
                S_IDLE: begin
                    flushing <= 1'b0;
                    if (start) begin
                        curSymbol <= symbol;
                        subStart <= 1'b1;
                        state <= S_SUB;
                    end
                end
                S_SUB: if (subDone) state <= S_RESCALE;
                S_RESCALE: begin
                    if (emitPort.emit) state <= S_PENDING;
                    else if (emitPort.addPending) pendCnt <= pendCnt + 1'b1;
                    else if (curSymbol == codecModelPkg::EOF_SYMBOL) state <= S_FINISH;
                    else state <= S_SYM_WAIT;
                end
                S_FINISH: begin
                    pendCnt <= pendCnt + 1'b1;
                    flushing <= 1'b1;
                    state <= S_FLUSH_BIT;
                end
                S_FLUSH_BIT: state <= S_PENDING;
                S_PENDING: begin
                    if (emitPort.wordFull) begin
                        retState <= S_PENDING;
                        state <= S_READ;
                    end else if (pendCnt == '0) begin
                        state <= flushing ? S_FLUSH : S_RESCALE;
                    end else begin
                        pendCnt <= pendCnt - 1'b1;  // packer writes one this cycle
                    end
                end
                S_FLUSH: state <= S_FLUSHED;
                S_FLUSHED: begin
                    retState <= S_IDLE;
                    state <= emitPort.wordFull ? S_READ : S_IDLE;
                end
                S_READ: if (readSuccess) state <= S_READ_ACK;
                S_READ_ACK: if (!readSuccess) state <= retState;
                S_SYM_WAIT: if (newSymbolProvided) begin
                    curSymbol <= symbol;
                    state <= S_SYM_ACK;
                end
                S_SYM_ACK: if (!newSymbolProvided) begin
                    subStart <= 1'b1;
                    state <= S_SUB;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // the host only reads held words and the packer never drops a bit
    assert property (@(posedge clk) disable iff (!rstn) resultReady |-> emitPort.wordFull);
    assert property (@(posedge clk) disable iff (!rstn) emitPort.emit |-> !emitPort.wordFull);

endmodule

// ==== verilog/intervalUnit.sv ====
// interval registers, subinterval computation through the divider and rescale operations
`timescale 1ns/1ps

module intervalUnit (
    input  logic clk,
    input  logic rstn,
    input  codecParamPkg::intervalOp_e op,
    input  logic [codecModelPkg::SYMBOL_W-1:0] symbol,
    input  logic subStart,
    output logic subDone,
    output logic [codecParamPkg::PRECISION-1:0] low,
    output logic [codecParamPkg::PRECISION-1:0] high,
    divIf.master div
);

    typedef enum logic [1:0] {PH_IDLE, PH_HIGH, PH_LOW} phase_e;

    phase_e phase;
    logic [codecParamPkg::PRECISION-1:0] a;
    logic [codecParamPkg::PRECISION-1:0] b;
    logic [codecParamPkg::PRECISION-1:0] w;
    logic [codecParamPkg::PROD_W-1:0] prodHigh;
    logic [codecParamPkg::PROD_W-1:0] prodLow;
    logic [codecParamPkg::PRECISION-1:0] step;

    assign prodHigh = codecParamPkg::PROD_W'(w)
                    * codecParamPkg::PROD_W'(codecModelPkg::CUM_FREQ[symbol + 1'b1]);
    assign prodLow = codecParamPkg::PROD_W'(w)
                   * codecParamPkg::PROD_W'(codecModelPkg::CUM_FREQ[symbol]);
    assign step = div.quotient[codecParamPkg::PRECISION-1:0];   // never above w
    assign div.divisor = codecModelPkg::TOTAL_FREQ;
    assign low = a;
    assign high = b;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            phase <= PH_IDLE;
            div.start <= 1'b0;
            subDone <= 1'b0;
            a <= '0;
            b <= codecParamPkg::WHOLE;
            w <= codecParamPkg::WHOLE;
        end else begin
            div.start <= 1'b0;
            subDone <= 1'b0;
            unique case (phase)
                PH_IDLE: if (subStart) begin
                    div.start <= 1'b1;
                    div.dividend <= prodHigh;
                    phase <= PH_HIGH;
                end
                PH_HIGH: if (div.done) begin
                    b <= a + step;                 // old a, updated next
                    div.start <= 1'b1;
                    div.dividend <= prodLow;
                    phase <= PH_LOW;
                end
                PH_LOW: if (div.done) begin
                    a <= a + step;
                    subDone <= 1'b1;
                    phase <= PH_IDLE;
                end
                default: phase <= PH_IDLE;
            endcase
            unique case (op)
                codecParamPkg::OP_LOAD: begin
                    a <= '0;
                    b <= codecParamPkg::WHOLE;
                    w <= codecParamPkg::WHOLE;
                end
                codecParamPkg::OP_LOW: begin
                    a <= a << 1;
                    b <= b << 1;
                end
                codecParamPkg::OP_HIGH: begin
                    a <= (a - codecParamPkg::HALF) << 1;
                    b <= (b - codecParamPkg::HALF) << 1;
                end
                codecParamPkg::OP_MID: begin
                    a <= (a - codecParamPkg::QUARTER) << 1;
                    b <= (b - codecParamPkg::QUARTER) << 1;
                end
                codecParamPkg::OP_WIDTH: w <= b - a;
                default: ;
            endcase
        end
    end

    // every rescale step chosen by the FSM must keep the interval non-empty
    assert property (@(posedge clk) disable iff (!rstn)
        (op != codecParamPkg::OP_NONE) |=> (a < b));

endmodule

// ==== verilog/seqDivider.sv ====
// restoring divider producing one quotient bit per cycle
`timescale 1ns/1ps

module seqDivider (
    input logic clk,
    input logic rstn,
    divIf.slave div
);

    logic busy;
    logic [5:0] bitCnt;
    logic [codecModelPkg::FREQ_W-1:0] rem;
    logic [codecModelPkg::FREQ_W-1:0] divisorQ;
    logic [codecParamPkg::PROD_W-1:0] quo;         // dividend shifts out, quotient shifts in
    logic [codecModelPkg::FREQ_W:0] shifted;
    logic [codecModelPkg::FREQ_W:0] diff;

    assign shifted = {rem, quo[codecParamPkg::PROD_W-1]};
    assign diff = shifted - {1'b0, divisorQ};       // msb set means borrow
    assign div.quotient = quo;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            bitCnt <= '0;
            div.done <= 1'b0;
        end else begin
            div.done <= 1'b0;
            if (div.start) begin
                busy <= 1'b1;
                bitCnt <= 6'(codecParamPkg::PROD_W);
            end else if (busy) begin
                bitCnt <= bitCnt - 6'd1;
                if (bitCnt == 6'd1) begin
                    busy <= 1'b0;
                    div.done <= 1'b1;                // last quotient bit lands this edge
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div.start) begin
            rem <= '0;
            quo <= div.dividend;
            divisorQ <= div.divisor;
        end else if (busy) begin
            if (!diff[codecModelPkg::FREQ_W]) begin
                rem <= diff[codecModelPkg::FREQ_W-1:0];
                quo <= {quo[codecParamPkg::PROD_W-2:0], 1'b1};
            end else begin
                rem <= shifted[codecModelPkg::FREQ_W-1:0];
                quo <= {quo[codecParamPkg::PROD_W-2:0], 1'b0};
            end
        end
    end

    // the interval unit waits for done before asking again
    assert property (@(posedge clk) disable iff (!rstn) div.start |-> !busy);

endmodule
